//--- source/n64_ppu_settings.svh
// N64 front end constants for bus widths, line thresholds and data timeouts
`ifndef N64_PPU_SETTINGS_SVH
`define N64_PPU_SETTINGS_SVH

// ========================================
// video bus widths
// ========================================

// one colour byte on the N64 bus
`define COLOR_W_I 7

// one colour after 7-to-8-bit expansion
`define COLOR_W_O 8

// sync flags occupy the low nibble of the sync byte
`define SYNC_W 4

// ========================================
// video info detection
// ========================================

// line counter width, enough for both NTSC and PAL fields
`define LINE_CNT_W 10

// more lines per field than this means PAL
`define PAL_LINE_THRESHOLD 287

// N64 clock cycles without a sync phase before data counts as lost
`define VDATA_TIMEOUT 64

// flip-flops in the configuration synchroniser
`define CFG_SYNC_STAGES 2

`endif

//--- source/n64_ppu_pkg.sv
// shared colour, sync flag and video info types of the N64 front end
`include "n64_ppu_settings.svh"

package n64_ppu_pkg;

  // colour byte as it arrives on VD_i
  typedef logic [`COLOR_W_I-1:0] color_in_t;

  // colour value after expansion
  typedef logic [`COLOR_W_O-1:0] color_out_t;

  // sync flags, all active low, bit 3 down to bit 0 of the sync byte
  typedef struct packed {
    logic vsync_n;
    logic clamp_n;
    logic hsync_n;
    logic csync_n;
  } sync_t;

  // video information extracted from the sync stream
  typedef struct packed {
    logic vdata_detected;
    logic palmode;
    logic n64_480i;
  } vinfo_t;

endpackage

//--- source/n64_vinfo.sv
// video info extraction: data detected, PAL mode and 480i from the N64 sync bytes
`timescale 1ns/1ps
`include "n64_ppu_settings.svh"

module n64_vinfo (
  input  logic                N64_CLK_i,
  input  logic                rst_n_i,
  input  logic                nVDSYNC_i,
  input  n64_ppu_pkg::sync_t  sync_i,
  output n64_ppu_pkg::vinfo_t vinfo_o
);

  localparam int nodata_w = $clog2(`VDATA_TIMEOUT);

  n64_ppu_pkg::sync_t  sync_prev_q;
  n64_ppu_pkg::vinfo_t vinfo_q;

  logic [`LINE_CNT_W-1:0] line_cnt_q;
  logic [nodata_w-1:0]    nodata_cnt_q;
  logic [1:0]             field_cnt_q;
  logic                   hs_at_vs_q;

  logic vs_fall_w;
  logic hs_fall_w;
  logic timeout_w;

  // ========================================
  // sync edge detection
  // ========================================

  // sync flags are only meaningful during the sync phase
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      sync_prev_q <= '1;
    end else if (!nVDSYNC_i) begin
      sync_prev_q <= sync_i;
    end
  end

  assign vs_fall_w = !nVDSYNC_i && sync_prev_q.vsync_n && !sync_i.vsync_n;
  assign hs_fall_w = !nVDSYNC_i && sync_prev_q.hsync_n && !sync_i.hsync_n;

  // ========================================
  // no-data watchdog
  // ========================================

  // restarts on every sync phase, holds at the limit
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      nodata_cnt_q <= '0;
    end else if (!nVDSYNC_i) begin
      nodata_cnt_q <= '0;
    end else if (nodata_cnt_q != nodata_w'(`VDATA_TIMEOUT - 1)) begin
      nodata_cnt_q <= nodata_cnt_q + 1'b1;
    end
  end

  assign timeout_w = nVDSYNC_i && (nodata_cnt_q == nodata_w'(`VDATA_TIMEOUT - 1));

  // ========================================
  // line counting and mode decision
  // ========================================

  // a line starting together with vsync belongs to the new field
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      line_cnt_q <= '0;
    end else if (timeout_w) begin
      line_cnt_q <= '0;
    end else if (vs_fall_w) begin
      line_cnt_q <= hs_fall_w ? `LINE_CNT_W'(1) : '0;
    end else if (hs_fall_w && line_cnt_q != '1) begin
      line_cnt_q <= line_cnt_q + 1'b1;
    end
  end

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vinfo_q     <= '0;
      field_cnt_q <= '0;
      hs_at_vs_q  <= 1'b1;
    end else if (timeout_w) begin
      vinfo_q     <= '0;
      field_cnt_q <= '0;
    end else if (vs_fall_w) begin
      vinfo_q.palmode <= (line_cnt_q > `LINE_CNT_W'(`PAL_LINE_THRESHOLD));
      // interlaced fields alternate the hsync level at the vsync edge
      vinfo_q.n64_480i <= (sync_i.hsync_n != hs_at_vs_q);
      hs_at_vs_q       <= sync_i.hsync_n;
      if (field_cnt_q != 2'd2) begin
        field_cnt_q <= field_cnt_q + 1'b1;
      end
      // second vsync edge confirms a running video stream
      if (field_cnt_q != 2'd0) begin
        vinfo_q.vdata_detected <= 1'b1;
      end
    end
  end

  assign vinfo_o = vinfo_q;

endmodule

//--- source/n64_vdemux.sv
// N64 video demux: config sync, bus phase tracking, pixel assembly and colour expansion
`timescale 1ns/1ps
`include "n64_ppu_settings.svh"

module n64_vdemux (
  input  logic                    N64_CLK_i,
  input  logic                    rst_n_i,
  input  logic                    nVDSYNC_i,
  input  n64_ppu_pkg::color_in_t  VD_i,
  input  logic                    cfg_n16bit_mode_i,
  output logic                    vdata_valid_o,
  output n64_ppu_pkg::sync_t      sync_o,
  output n64_ppu_pkg::color_out_t r_o,
  output n64_ppu_pkg::color_out_t g_o,
  output n64_ppu_pkg::color_out_t b_o
);

  logic [`CFG_SYNC_STAGES-1:0] cfg_sync_q;
  logic                        n16bit_w;

  logic [1:0] phase_q;
  logic       pix_act_q;

  n64_ppu_pkg::color_in_t vd_q;
  n64_ppu_pkg::sync_t     sync_hold_q;
  n64_ppu_pkg::color_in_t r_hold_q;
  n64_ppu_pkg::color_in_t g_hold_q;

  // 16-bit mode drops the two LSBs, then the MSB is repeated below the LSB
  function automatic n64_ppu_pkg::color_out_t expand_color(
    input n64_ppu_pkg::color_in_t c_in,
    input logic                   n16bit
  );
    n64_ppu_pkg::color_in_t c_m;
    c_m = n16bit ? c_in : {c_in[`COLOR_W_I-1:2], 2'b00};
    return {c_m, c_m[`COLOR_W_I-1]};
  endfunction

  // ========================================
  // configuration synchroniser
  // ========================================

  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_sync_q <= '1;
    end else begin
      cfg_sync_q <= {cfg_sync_q[`CFG_SYNC_STAGES-2:0], cfg_n16bit_mode_i};
    end
  end

  assign n16bit_w = cfg_sync_q[`CFG_SYNC_STAGES-1];

  // ========================================
  // bus phase tracking
  // ========================================

  // phase_q tells which byte sits in vd_q
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      phase_q   <= 2'd0;
      pix_act_q <= 1'b0;
    end else if (!nVDSYNC_i) begin
      phase_q   <= 2'd0;
      pix_act_q <= 1'b1;
    end else if (pix_act_q) begin
      phase_q <= phase_q + 1'b1;
      if (phase_q == 2'd3) begin
        pix_act_q <= 1'b0;
      end
    end
  end

  // ========================================
  // pixel assembly
  // ========================================

  always_ff @(posedge N64_CLK_i) begin
    vd_q <= VD_i;
    if (pix_act_q) begin
      case (phase_q)
        2'd0:    sync_hold_q <= n64_ppu_pkg::sync_t'(vd_q[`SYNC_W-1:0]);
        2'd1:    r_hold_q    <= vd_q;
        2'd2:    g_hold_q    <= vd_q;
        default: ;
      endcase
    end
  end

  // blue byte completes the pixel, outputs hold until the next one
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vdata_valid_o <= 1'b0;
      sync_o        <= '1;
      r_o           <= '0;
      g_o           <= '0;
      b_o           <= '0;
    end else if (pix_act_q && phase_q == 2'd3) begin
      vdata_valid_o <= 1'b1;
      sync_o        <= sync_hold_q;
      r_o           <= expand_color(r_hold_q, n16bit_w);
      g_o           <= expand_color(g_hold_q, n16bit_w);
      b_o           <= expand_color(vd_q, n16bit_w);
    end else begin
      vdata_valid_o <= 1'b0;
    end
  end

endmodule

//--- source/n64_ppu_top.sv
// N64 post-processing front end: video demux and video info extraction
`timescale 1ns/1ps
`include "n64_ppu_settings.svh"

module n64_ppu_top (
  input  logic                    N64_CLK_i,
  input  logic                    rst_n_i,
  input  logic                    nVDSYNC_i,
  input  n64_ppu_pkg::color_in_t  VD_i,
  input  logic                    cfg_n16bit_mode_i,
  output logic                    vdata_valid_o,
  output logic                    VSYNC_o,
  output logic                    HSYNC_o,
  output logic                    CSYNC_o,
  output n64_ppu_pkg::color_out_t R_o,
  output n64_ppu_pkg::color_out_t G_o,
  output n64_ppu_pkg::color_out_t B_o,
  output logic                    vdata_detected_o,
  output logic                    palmode_o,
  output logic                    n64_480i_o
);

  n64_ppu_pkg::sync_t  vd_sync_w;
  n64_ppu_pkg::sync_t  sync_w;
  n64_ppu_pkg::vinfo_t vinfo_w;

  // raw sync nibble, only valid while nVDSYNC_i is low
  assign vd_sync_w = n64_ppu_pkg::sync_t'(VD_i[`SYNC_W-1:0]);

  // ========================================
  // video info
  // ========================================

  n64_vinfo vinfo_u (
    .N64_CLK_i (N64_CLK_i),
    .rst_n_i   (rst_n_i),
    .nVDSYNC_i (nVDSYNC_i),
    .sync_i    (vd_sync_w),
    .vinfo_o   (vinfo_w)
  );

  assign vdata_detected_o = vinfo_w.vdata_detected;
  assign palmode_o        = vinfo_w.palmode;
  assign n64_480i_o       = vinfo_w.n64_480i;

  // ========================================
  // video demux
  // ========================================

  n64_vdemux vdemux_u (
    .N64_CLK_i         (N64_CLK_i),
    .rst_n_i           (rst_n_i),
    .nVDSYNC_i         (nVDSYNC_i),
    .VD_i              (VD_i),
    .cfg_n16bit_mode_i (cfg_n16bit_mode_i),
    .vdata_valid_o     (vdata_valid_o),
    .sync_o            (sync_w),
    .r_o               (R_o),
    .g_o               (G_o),
    .b_o               (B_o)
  );

  // clamp is consumed on the N64 side only
  assign VSYNC_o = sync_w.vsync_n;
  assign HSYNC_o = sync_w.hsync_n;
  assign CSYNC_o = sync_w.csync_n;

endmodule

//--- test/tb_clk_gen.sv
// testbench clock source for the N64 clock, 100 ns period
`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #50 clk_o = ~clk_o;

endmodule

//--- test/n64_ppu_chk.sv
// bound checker on the N64 front end ports: pixel strobe, colours, sync and video info
`timescale 1ns/1ps
`include "n64_ppu_settings.svh"

module n64_ppu_chk (
  input logic                    N64_CLK_i,
  input logic                    rst_n_i,
  input logic                    nVDSYNC_i,
  input n64_ppu_pkg::color_in_t  VD_i,
  input logic                    cfg_n16bit_mode_i,
  input logic                    vdata_valid_o,
  input logic                    VSYNC_o,
  input logic                    HSYNC_o,
  input logic                    CSYNC_o,
  input n64_ppu_pkg::color_out_t R_o,
  input n64_ppu_pkg::color_out_t G_o,
  input n64_ppu_pkg::color_out_t B_o,
  input logic                    vdata_detected_o,
  input logic                    palmode_o,
  input logic                    n64_480i_o
);

  int err_cnt = 0;

  n64_ppu_pkg::color_in_t vd_d [1:5];
  logic [5:1] ns_d;
  logic [2:0] cfg_hi_cnt;
  logic [2:0] cfg_lo_cnt;
  logic [7:0] idle_cnt;
  logic       started_q;
  logic       strobe_q;

  // colour rule: optional 16-bit cut, then MSB appended
  function automatic n64_ppu_pkg::color_out_t exp_col(n64_ppu_pkg::color_in_t c, logic cut);
    n64_ppu_pkg::color_in_t m;
    m = cut ? {c[`COLOR_W_I-1:2], 2'b00} : c;
    return {m, m[`COLOR_W_I-1]};
  endfunction

  // history of the bus and of the configuration level
  always_ff @(posedge N64_CLK_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ns_d       <= '1;
      cfg_hi_cnt <= '0;
      cfg_lo_cnt <= '0;
      idle_cnt   <= '0;
      started_q  <= 1'b0;
      strobe_q   <= 1'b0;
    end else begin
      ns_d       <= {ns_d[4:1], nVDSYNC_i};
      cfg_hi_cnt <= !cfg_n16bit_mode_i ? 3'd0 : cfg_hi_cnt + 3'(cfg_hi_cnt != 3'd7);
      cfg_lo_cnt <= cfg_n16bit_mode_i ? 3'd0 : cfg_lo_cnt + 3'(cfg_lo_cnt != 3'd7);
      idle_cnt   <= !nVDSYNC_i ? 8'd0 : idle_cnt + 8'(idle_cnt != 8'hff);
      started_q  <= started_q | !nVDSYNC_i;
      strobe_q   <= strobe_q | vdata_valid_o;
    end
  end

  always_ff @(posedge N64_CLK_i) begin
    vd_d[1] <= VD_i;
    for (int i = 2; i <= 5; i++) begin
      vd_d[i] <= vd_d[i-1];
    end
  end

  // ========================================
  // assertions
  // ========================================

  a_reset: assert property (@(posedge N64_CLK_i) disable iff (!rst_n_i)
    !started_q |-> !vdata_valid_o && !vdata_detected_o && !palmode_o && !n64_480i_o)
    else begin
      err_cnt++;
      $error("mismatch vdata_valid_o and vinfo after reset: got %h expected 0",
        {vdata_valid_o, vdata_detected_o, palmode_o, n64_480i_o});
    end

  // sync outputs stay inactive until the first pixel is presented
  a_sync_idle: assert property (@(posedge N64_CLK_i) disable iff (!rst_n_i)
    !strobe_q && !vdata_valid_o |-> VSYNC_o && HSYNC_o && CSYNC_o)
    else begin
      err_cnt++;
      $error("mismatch sync outputs: got %h expected 7", {VSYNC_o, HSYNC_o, CSYNC_o});
    end

  // pixel strobe four edges after the sampled sync phase
  a_strobe: assert property (@(posedge N64_CLK_i) disable iff (!rst_n_i)
    vdata_valid_o == !ns_d[5])
    else begin
      err_cnt++;
      $error("mismatch vdata_valid_o: got %h expected %h", vdata_valid_o, !ns_d[5]);
    end

  a_sync: assert property (@(posedge N64_CLK_i) disable iff (!rst_n_i)
    vdata_valid_o |-> {VSYNC_o, HSYNC_o, CSYNC_o} == {vd_d[5][3], vd_d[5][1], vd_d[5][0]})
    else begin
      err_cnt++;
      $error("mismatch sync outputs: got %h expected %h",
        {VSYNC_o, HSYNC_o, CSYNC_o}, {vd_d[5][3], vd_d[5][1], vd_d[5][0]});
    end

  a_color: assert property (@(posedge N64_CLK_i) disable iff (!rst_n_i)
    vdata_valid_o && cfg_hi_cnt >= 3'd3 |->
      {R_o, G_o, B_o} == {exp_col(vd_d[4], 1'b0), exp_col(vd_d[3], 1'b0), exp_col(vd_d[2], 1'b0)})
    else begin
      err_cnt++;
      $error("mismatch R_o G_o B_o: got %h expected %h", {R_o, G_o, B_o},
        {exp_col(vd_d[4], 1'b0), exp_col(vd_d[3], 1'b0), exp_col(vd_d[2], 1'b0)});
    end

  a_cut: assert property (@(posedge N64_CLK_i) disable iff (!rst_n_i)
    vdata_valid_o && cfg_lo_cnt >= 3'(`CFG_SYNC_STAGES + 1) |->
      {R_o, G_o, B_o} == {exp_col(vd_d[4], 1'b1), exp_col(vd_d[3], 1'b1), exp_col(vd_d[2], 1'b1)})
    else begin
      err_cnt++;
      $error("mismatch 16-bit R_o G_o B_o: got %h expected %h", {R_o, G_o, B_o},
        {exp_col(vd_d[4], 1'b1), exp_col(vd_d[3], 1'b1), exp_col(vd_d[2], 1'b1)});
    end

  a_timeout: assert property (@(posedge N64_CLK_i) disable iff (!rst_n_i)
    idle_cnt >= 8'(`VDATA_TIMEOUT) |-> !vdata_detected_o && !palmode_o && !n64_480i_o)
    else begin
      err_cnt++;
      $error("mismatch vinfo after data loss: got %h expected 0",
        {vdata_detected_o, palmode_o, n64_480i_o});
    end

endmodule

//--- test/tb_n64_ppu.sv
// testbench top for the N64 front end: NTSC, PAL and interlaced fields, data loss
`timescale 1ns/1ps
`include "n64_ppu_settings.svh"

module tb_n64_ppu;

  logic                    clk;
  logic                    rst_n;
  logic                    nvdsync;
  n64_ppu_pkg::color_in_t  vd;
  logic                    cfg_n16bit;
  logic                    valid;
  logic                    vs;
  logic                    hs;
  logic                    cs;
  logic                    det;
  logic                    pal;
  logic                    i480;
  n64_ppu_pkg::color_out_t r;
  n64_ppu_pkg::color_out_t g;
  n64_ppu_pkg::color_out_t b;
  integer                  seed = 32'hbe23_ab34;

  tb_clk_gen clk_gen_u (.clk_o(clk));

  n64_ppu_top n64_ppu_top_inst (
    .N64_CLK_i(clk), .rst_n_i(rst_n), .nVDSYNC_i(nvdsync), .VD_i(vd),
    .cfg_n16bit_mode_i(cfg_n16bit), .vdata_valid_o(valid), .VSYNC_o(vs),
    .HSYNC_o(hs), .CSYNC_o(cs), .R_o(r), .G_o(g), .B_o(b),
    .vdata_detected_o(det), .palmode_o(pal), .n64_480i_o(i480)
  );

  bind n64_ppu_top n64_ppu_chk chk_u (.*);

  task automatic report_fail(input string what);
    $display("%s", what);
    $display("Something failed");
    $fatal(1, "stopping on first error");
  endtask

  // one sync phase followed by three random colour bytes
  task automatic send_pixel(input logic vs_n, input logic hs_n);
    @(posedge clk);
    #1;
    nvdsync = 1'b0;
    vd      = {3'b000, vs_n, 1'b1, hs_n, vs_n & hs_n};
    for (int i = 0; i < 3; i++) begin
      @(posedge clk);
      #1;
      nvdsync = 1'b1;
      vd      = 7'($random(seed));
    end
  endtask

  // lines of 4 pixels, hsync on pixel 0, vsync on pixel 0 or 1 of line 0
  task automatic send_field(input int lines, input int vs_pix);
    for (int l = 0; l < lines; l++) begin
      for (int p = 0; p < 4; p++) begin
        send_pixel(!(l == 0 && p == vs_pix), p != 0);
      end
    end
  endtask

  function automatic logic info_bit(input int sel);
    case (sel)
      0:       return det;
      1:       return pal;
      default: return i480;
    endcase
  endfunction

  task automatic wait_level(input int sel, input logic val, input string name);
    int n;
    n = 0;
    while (info_bit(sel) !== val && n < 4 * `VDATA_TIMEOUT) begin
      @(posedge clk);
      #1;
      n++;
    end
    if (info_bit(sel) !== val) begin
      report_fail($sformatf("timeout waiting for %s to become %0d", name, val));
    end
  endtask

  always @(negedge clk) begin
    if (n64_ppu_top_inst.chk_u.err_cnt != 0) begin
      report_fail("checker assertion failed");
    end
  end

  initial begin
    rst_n      = 1'b0;
    nvdsync    = 1'b1;
    vd         = '0;
    cfg_n16bit = 1'b1;
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;

    // ntsc, two vsync edges bring up detection
    repeat (3) send_field(262, 0);
    wait_level(0, 1'b1, "vdata_detected_o");
    wait_level(1, 1'b0, "palmode_o");
    wait_level(2, 1'b0, "n64_480i_o");

    // pal decided at the edge that closes the first pal field
    repeat (2) send_field(312, 0);
    wait_level(1, 1'b1, "palmode_o");

    // interlaced pair, hsync level alternates at vsync
    send_field(262, 1);
    send_field(262, 0);
    wait_level(2, 1'b1, "n64_480i_o");
    send_field(262, 0);
    wait_level(2, 1'b0, "n64_480i_o");

    // 16-bit colour on an interlaced pal field, then data loss
    @(posedge clk);
    #1;
    cfg_n16bit = 1'b0;
    send_field(312, 1);
    send_field(8, 0);
    wait_level(1, 1'b1, "palmode_o");
    wait_level(2, 1'b1, "n64_480i_o");
    @(posedge clk);
    #1;
    nvdsync = 1'b1;
    wait_level(0, 1'b0, "vdata_detected_o");
    repeat (4) @(posedge clk);

    if (n64_ppu_top_inst.chk_u.err_cnt == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      report_fail("checker reported errors");
    end
  end

endmodule

//--- compile.f
+incdir+source
source/n64_ppu_pkg.sv
source/n64_vinfo.sv
source/n64_vdemux.sv
source/n64_ppu_top.sv
test/tb_clk_gen.sv
test/n64_ppu_chk.sv
test/tb_n64_ppu.sv

//--- run_sim.sh
#!/bin/sh
# builds the N64 front end testbench with Verilator and runs it

LOG=sim.log

verilator --binary -sv --assert --timing -Isource \
  -f compile.f --top-module tb_n64_ppu -o sim_n64_ppu
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

# keep running after a checker error so the testbench can report it
./obj_dir/sim_n64_ppu +verilator+error+limit+1000 > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
fi

if grep -q "^Everything OK$" "$LOG"; then
  echo "PASS"
  exit 0
fi
echo "FAIL"
exit 1
